// ==== filelist.f ====
logic/isaPkg.sv
logic/pipePkg.sv
logic/stageReg.sv
logic/instrDecoder.sv
logic/regFile.sv
logic/execAlu.sv
logic/hazardUnit.sv
logic/loadStoreUnit.sv
logic/cpuDatapath.sv
tests/cpuDatapathTb.sv

// ==== logic/cpuDatapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuDatapath (
    input  var logic           clk,
    input  var logic           rstN_i,
    output isaPkg::wordT       instAddr_o,
    output logic               instEn_o,
    input  var isaPkg::wordT   instr_i,
    output logic               memEn_o,
    output isaPkg::wordT       memAddr_o,
    output logic [3:0]         memWriteSel_o,
    output isaPkg::wordT       memWdata_o,
    input  var isaPkg::wordT   memRdata_i,
    input  var logic           dataStall_i,
    output isaPkg::wordT       debugWbPc_o,
    output logic [3:0]         debugWbRfWen_o,
    output isaPkg::regIdxT     debugWbRfWnum_o,
    output isaPkg::wordT       debugWbRfWdata_o
);

    import isaPkg::*;
    import pipePkg::*;

    wordT     pcF;
    wordT     pcNext;
    logic     fetchOn;
    fetchDecT fdIn, fdOut;
    decExecT  deIn, deOut;
    execMemT  emIn, emOut;
    memWbT    mwIn, mwOut;
    rTypeT    instrD;
    ctrlT     ctrlD;
    regIdxT   destD;
    wordT     immD, rsRegD, rtRegD, rsValD, rtValD, branchTarget;
    logic     branchTaken;
    fwdSelT   fwdA, fwdB;
    logic     stallFD, bubbleE, freeze;
    wordT     srcBE, aluResultE;
    logic [4:0] shamtE;
    wordT     loadDataM, resultM;
    logic     wbWrite;

    // fetch
    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            pcF     <= bootVector;
            fetchOn <= 1'b0;
        end else begin
            fetchOn <= 1'b1;  // first fetch one cycle after reset
            if (fetchOn && !stallFD) begin
                pcF <= pcNext;
            end
        end
    end

    assign pcNext     = branchTaken ? branchTarget : pcF + 32'd4;
    assign instAddr_o = pcF;
    assign instEn_o   = fetchOn & ~stallFD;
    assign fdIn       = '{pc: pcF, instr: instr_i};

    stageReg #(.payloadT(fetchDecT)) fetchDecReg (
        .clk(clk), .rstN_i(rstN_i), .stall_i(stallFD), .bubble_i(~fetchOn),
        .d_i(fdIn), .q_o(fdOut)
    );

    // decode, branch resolves here
    assign instrD = rTypeT'(fdOut.instr);

    instrDecoder decoder (
        .instr_i(fdOut.instr), .ctrl_o(ctrlD), .imm_o(immD), .dest_o(destD)
    );

    regFile regs (
        .clk(clk), .rstN_i(rstN_i), .we_i(wbWrite), .waddr_i(mwOut.dest),
        .wdata_i(mwOut.result), .raddr1_i(instrD.rs), .raddr2_i(instrD.rt),
        .rdata1_o(rsRegD), .rdata2_o(rtRegD)
    );

    function automatic wordT fwdMux(fwdSelT sel, wordT regVal);
        case (sel)
            fwdExec: return aluResultE;
            fwdMem:  return resultM;
            fwdWb:   return mwOut.result;
            default: return regVal;
        endcase
    endfunction

    always_comb begin
        rsValD = fwdMux(fwdA, rsRegD);
        rtValD = fwdMux(fwdB, rtRegD);
    end

    assign branchTarget = fdOut.pc + 32'd4 + {immD[29:0], 2'b00};
    assign branchTaken  = ctrlD.isBranch && ((rsValD == rtValD) != ctrlD.branchNe);

    assign deIn = '{pc: fdOut.pc, rsVal: rsValD, rtVal: rtValD, imm: immD,
                    shamt: instrD.shamt, dest: destD, ctrl: ctrlD};

    stageReg #(.payloadT(decExecT)) decExecReg (
        .clk(clk), .rstN_i(rstN_i), .stall_i(freeze), .bubble_i(bubbleE),
        .d_i(deIn), .q_o(deOut)
    );

    // execute
    assign srcBE  = deOut.ctrl.isImm ? deOut.imm : deOut.rtVal;
    assign shamtE = deOut.ctrl.useShamt ? deOut.shamt : 5'd0;

    execAlu alu (
        .srcA_i(deOut.rsVal), .srcB_i(srcBE), .shamt_i(shamtE),
        .aluOp_i(deOut.ctrl.aluOp), .result_o(aluResultE)
    );

    assign emIn = '{pc: deOut.pc, aluResult: aluResultE, storeData: deOut.rtVal,
                    dest: deOut.dest, ctrl: deOut.ctrl};

    stageReg #(.payloadT(execMemT)) execMemReg (
        .clk(clk), .rstN_i(rstN_i), .stall_i(freeze), .bubble_i(1'b0),
        .d_i(emIn), .q_o(emOut)
    );

    // memory
    loadStoreUnit lsu (
        .addr_i(emOut.aluResult), .storeData_i(emOut.storeData), .memRdata_i(memRdata_i),
        .ctrl_i(emOut.ctrl), .writeSel_o(memWriteSel_o), .wdata_o(memWdata_o),
        .loadData_o(loadDataM)
    );

    assign memEn_o   = emOut.ctrl.memRead | emOut.ctrl.memWrite;
    assign memAddr_o = emOut.aluResult;
    assign resultM   = emOut.ctrl.memRead ? loadDataM : emOut.aluResult;
    assign mwIn      = '{pc: emOut.pc, result: resultM, dest: emOut.dest,
                         regWrite: emOut.ctrl.regWrite};

    stageReg #(.payloadT(memWbT)) memWbReg (
        .clk(clk), .rstN_i(rstN_i), .stall_i(freeze), .bubble_i(1'b0),
        .d_i(mwIn), .q_o(mwOut)
    );

    // writeback, one report per instruction even across a freeze
    assign wbWrite          = mwOut.regWrite & ~freeze;
    assign debugWbPc_o      = mwOut.pc;
    assign debugWbRfWen_o   = {4{wbWrite}};
    assign debugWbRfWnum_o  = mwOut.dest;
    assign debugWbRfWdata_o = mwOut.result;

    hazardUnit hazards (
        .rsD_i(instrD.rs), .rtD_i(instrD.rt),
        .destE_i(deOut.dest), .destM_i(emOut.dest), .destW_i(mwOut.dest),
        .regWriteE_i(deOut.ctrl.regWrite), .regWriteM_i(emOut.ctrl.regWrite),
        .regWriteW_i(mwOut.regWrite), .memReadE_i(deOut.ctrl.memRead),
        .dataStall_i(dataStall_i), .fwdA_o(fwdA), .fwdB_o(fwdB),
        .stallFD_o(stallFD), .bubbleE_o(bubbleE), .freeze_o(freeze)
    );

endmodule

`default_nettype wire

// ==== logic/execAlu.sv ====
`timescale 1ns/1ps
`default_nettype none

module execAlu (
    input  var isaPkg::wordT  srcA_i,
    input  var isaPkg::wordT  srcB_i,
    input  var logic [4:0]    shamt_i,
    input  var isaPkg::aluOpT aluOp_i,
    output isaPkg::wordT      result_o
);

    import isaPkg::*;

    logic lessThan;

    assign lessThan = $signed(srcA_i) < $signed(srcB_i);

    always_comb begin
        case (aluOp_i)
            aluAdd:  result_o = srcA_i + srcB_i;  // no overflow trap
            aluSub:  result_o = srcA_i - srcB_i;
            aluAnd:  result_o = srcA_i & srcB_i;
            aluOr:   result_o = srcA_i | srcB_i;
            aluSlt:  result_o = {31'b0, lessThan};
            aluSll:  result_o = srcB_i << shamt_i;  // shifts rt
            aluLui:  result_o = {srcB_i[15:0], 16'b0};
            default: result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/hazardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  var isaPkg::regIdxT rsD_i,
    input  var isaPkg::regIdxT rtD_i,
    input  var isaPkg::regIdxT destE_i,
    input  var isaPkg::regIdxT destM_i,
    input  var isaPkg::regIdxT destW_i,
    input  var logic           regWriteE_i,
    input  var logic           regWriteM_i,
    input  var logic           regWriteW_i,
    input  var logic           memReadE_i,
    input  var logic           dataStall_i,
    output pipePkg::fwdSelT    fwdA_o,
    output pipePkg::fwdSelT    fwdB_o,
    output logic               stallFD_o,
    output logic               bubbleE_o,
    output logic               freeze_o
);

    import isaPkg::*;
    import pipePkg::*;

    logic loadUse;

    // youngest writer wins
    function automatic fwdSelT pickSource(regIdxT src);
        if (src == '0) return fwdRegFile;
        if (regWriteE_i && destE_i == src) return fwdExec;
        if (regWriteM_i && destM_i == src) return fwdMem;
        if (regWriteW_i && destW_i == src) return fwdWb;
        return fwdRegFile;
    endfunction

    always_comb begin
        fwdA_o = pickSource(rsD_i);
        fwdB_o = pickSource(rtD_i);
    end

    // load result only exists in the memory stage
    assign loadUse = memReadE_i && regWriteE_i && (destE_i == rsD_i || destE_i == rtD_i);

    assign freeze_o  = dataStall_i;
    assign stallFD_o = loadUse | dataStall_i;
    assign bubbleE_o = loadUse & ~dataStall_i;  // freeze keeps execute as is

endmodule

`default_nettype wire

// ==== logic/instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  var isaPkg::wordT instr_i,
    output pipePkg::ctrlT    ctrl_o,
    output isaPkg::wordT     imm_o,
    output isaPkg::regIdxT   dest_o
);

    import isaPkg::*;
    import pipePkg::*;

    rTypeT  rFields;
    iTypeT  iFields;
    ctrlT   ctrl;
    regIdxT dest;
    logic   known;
    logic   useRd;
    logic   zeroExt;

    assign rFields = rTypeT'(instr_i);
    assign iFields = iTypeT'(instr_i);

    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = aluAdd;
        known      = 1'b1;
        useRd      = 1'b0;
        zeroExt    = 1'b0;
        case (iFields.opcode)
            opSpecial: begin
                useRd         = 1'b1;
                ctrl.regWrite = 1'b1;
                case (rFields.funct)
                    fnAddu: ctrl.aluOp = aluAdd;
                    fnSubu: ctrl.aluOp = aluSub;
                    fnAnd:  ctrl.aluOp = aluAnd;
                    fnOr:   ctrl.aluOp = aluOr;
                    fnSlt:  ctrl.aluOp = aluSlt;
                    fnSll: begin
                        ctrl.aluOp    = aluSll;
                        ctrl.useShamt = 1'b1;
                    end
                    default: known = 1'b0;
                endcase
            end
            opAddiu: {ctrl.regWrite, ctrl.isImm} = 2'b11;
            opOri: begin
                {ctrl.regWrite, ctrl.isImm} = 2'b11;
                ctrl.aluOp = aluOr;
                zeroExt    = 1'b1;  // logical immediate
            end
            opLui: begin
                {ctrl.regWrite, ctrl.isImm} = 2'b11;
                ctrl.aluOp = aluLui;
            end
            opLw:  {ctrl.regWrite, ctrl.memRead, ctrl.isImm} = 3'b111;
            opLb: begin
                {ctrl.regWrite, ctrl.memRead, ctrl.isImm} = 3'b111;
                {ctrl.memByte, ctrl.memSigned} = 2'b11;
            end
            opLbu: begin
                {ctrl.regWrite, ctrl.memRead, ctrl.isImm} = 3'b111;
                ctrl.memByte = 1'b1;
            end
            opSw:  {ctrl.memWrite, ctrl.isImm} = 2'b11;
            opSb:  {ctrl.memWrite, ctrl.isImm, ctrl.memByte} = 3'b111;
            opBeq: ctrl.isBranch = 1'b1;
            opBne: {ctrl.isBranch, ctrl.branchNe} = 2'b11;
            default: known = 1'b0;
        endcase
        dest = useRd ? rFields.rd : rFields.rt;
        if (!known || dest == '0) begin
            ctrl.regWrite = 1'b0;  // $0 writes and unknown ops are dropped
        end
    end

    assign ctrl_o = ctrl;
    assign dest_o = dest;
    assign imm_o  = zeroExt ? {16'b0, iFields.imm} : {{16{iFields.imm[15]}}, iFields.imm};

endmodule

`default_nettype wire

// ==== logic/isaPkg.sv ====
`default_nettype none

package isaPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regIdxT;
    typedef logic [5:0]  opcodeT;
    typedef logic [5:0]  functT;

    // R-type field layout
    typedef struct packed {
        opcodeT     opcode;
        regIdxT     rs;
        regIdxT     rt;
        regIdxT     rd;
        logic [4:0] shamt;
        functT      funct;
    } rTypeT;

    // I-type field layout
    typedef struct packed {
        opcodeT      opcode;
        regIdxT      rs;
        regIdxT      rt;
        logic [15:0] imm;
    } iTypeT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,  // signed compare
        aluSll,
        aluLui
    } aluOpT;

    localparam wordT bootVector = 32'hBFC0_0000;

    localparam opcodeT opSpecial = 6'h00;  // R-type group
    localparam opcodeT opBeq     = 6'h04;
    localparam opcodeT opBne     = 6'h05;
    localparam opcodeT opAddiu   = 6'h09;
    localparam opcodeT opOri     = 6'h0D;
    localparam opcodeT opLui     = 6'h0F;
    localparam opcodeT opLb      = 6'h20;
    localparam opcodeT opLw      = 6'h23;
    localparam opcodeT opLbu     = 6'h24;
    localparam opcodeT opSb      = 6'h28;
    localparam opcodeT opSw      = 6'h2B;

    localparam functT fnSll  = 6'h00;
    localparam functT fnAddu = 6'h21;
    localparam functT fnSubu = 6'h23;
    localparam functT fnAnd  = 6'h24;
    localparam functT fnOr   = 6'h25;
    localparam functT fnSlt  = 6'h2A;

endpackage

`default_nettype wire

// ==== logic/loadStoreUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module loadStoreUnit (
    input  var isaPkg::wordT  addr_i,
    input  var isaPkg::wordT  storeData_i,
    input  var isaPkg::wordT  memRdata_i,
    input  var pipePkg::ctrlT ctrl_i,
    output logic [3:0]        writeSel_o,
    output isaPkg::wordT      wdata_o,
    output isaPkg::wordT      loadData_o
);

    import isaPkg::*;

    logic [1:0] lane;
    logic [7:0] loadByte;

    assign lane = addr_i[1:0];

    // store side
    always_comb begin
        writeSel_o = 4'b0000;  // loads never write
        wdata_o    = storeData_i;
        if (ctrl_i.memWrite) begin
            if (ctrl_i.memByte) begin
                writeSel_o = 4'b0001 << lane;
                wdata_o    = {4{storeData_i[7:0]}};  // byte on every lane
            end else begin
                writeSel_o = 4'b1111;
            end
        end
    end

    // load side, little-endian lanes
    assign loadByte = memRdata_i[8*lane +: 8];

    always_comb begin
        if (ctrl_i.memByte) begin
            if (ctrl_i.memSigned) begin
                loadData_o = {{24{loadByte[7]}}, loadByte};
            end else begin
                loadData_o = {24'b0, loadByte};
            end
        end else begin
            loadData_o = memRdata_i;
        end
    end

endmodule

`default_nettype wire

// ==== logic/pipePkg.sv ====
`default_nettype none

package pipePkg;

    typedef struct packed {
        logic          regWrite;
        logic          memRead;
        logic          memWrite;
        logic          memSigned;  // sign-extend byte loads
        logic          memByte;    // byte access, else word
        logic          isImm;      // alu srcB from immediate
        isaPkg::aluOpT aluOp;
        logic          useShamt;
        logic          isBranch;
        logic          branchNe;   // bne, else beq
    } ctrlT;

    typedef struct packed {
        isaPkg::wordT pc;
        isaPkg::wordT instr;
    } fetchDecT;

    typedef struct packed {
        isaPkg::wordT   pc;
        isaPkg::wordT   rsVal;  // already forwarded
        isaPkg::wordT   rtVal;
        isaPkg::wordT   imm;
        logic [4:0]     shamt;
        isaPkg::regIdxT dest;
        ctrlT           ctrl;
    } decExecT;

    typedef struct packed {
        isaPkg::wordT   pc;
        isaPkg::wordT   aluResult;
        isaPkg::wordT   storeData;
        isaPkg::regIdxT dest;
        ctrlT           ctrl;
    } execMemT;

    typedef struct packed {
        isaPkg::wordT   pc;
        isaPkg::wordT   result;
        isaPkg::regIdxT dest;
        logic           regWrite;
    } memWbT;

    typedef enum logic [1:0] {
        fwdRegFile,
        fwdExec,
        fwdMem,
        fwdWb
    } fwdSelT;

endpackage

`default_nettype wire

// ==== logic/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  var logic           clk,
    input  var logic           rstN_i,
    input  var logic           we_i,
    input  var isaPkg::regIdxT waddr_i,
    input  var isaPkg::wordT   wdata_i,
    input  var isaPkg::regIdxT raddr1_i,
    input  var isaPkg::regIdxT raddr2_i,
    output isaPkg::wordT       rdata1_o,
    output isaPkg::wordT       rdata2_o
);

    import isaPkg::*;

    wordT regs [1:31];  // no storage for $0

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // no write-through, writeback forwarding covers it
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

// ==== logic/stageReg.sv ====
`timescale 1ns/1ps
`default_nettype none

module stageReg #(
    parameter type payloadT = pipePkg::fetchDecT
) (
    input  var logic    clk,
    input  var logic    rstN_i,
    input  var logic    stall_i,
    input  var logic    bubble_i,
    input  var payloadT d_i,
    output payloadT     q_o
);

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            q_o <= '0;
        end else if (stall_i) begin
            q_o <= q_o;  // hold
        end else if (bubble_i) begin
            q_o <= '0;  // zero ctrl acts as a nop
        end else begin
            q_o <= d_i;
        end
    end

endmodule

`default_nettype wire

// ==== tests/cpuDatapathTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuDatapathTb;

    import isaPkg::*;

    typedef struct packed {
        wordT   pc;
        regIdxT num;
        wordT   data;
    } wbEntryT;

    typedef struct packed {
        wordT       addr;
        logic [3:0] sel;
        wordT       data;
    } storeEntryT;

    logic       clk;
    logic       rstN_i;
    logic       dataStall_i;
    logic       instEn_o;
    logic       memEn_o;
    logic [3:0] memWriteSel_o;
    logic [3:0] debugWbRfWen_o;
    wordT       instAddr_o, instr_i, memAddr_o, memWdata_o, memRdata_i;
    wordT       debugWbPc_o, debugWbRfWdata_o;
    regIdxT     debugWbRfWnum_o;

    wordT        rom [0:31];
    wordT        romOffset;
    logic [7:0]  dmem [0:1023];
    logic [7:0]  modelMem [0:1023];
    wordT        modelRegs [0:31];
    wbEntryT     expWb [$];
    storeEntryT  expSt [$];
    wbEntryT     wbExp;
    storeEntryT  stExp;
    int          progLen;
    int          lenSum;
    int          cycleCount;
    logic [31:0] rngState;
    logic        stallOn;
    string       testName;

    cpuDatapath cpuDatapath_inst (
        .clk(clk), .rstN_i(rstN_i),
        .instAddr_o(instAddr_o), .instEn_o(instEn_o), .instr_i(instr_i),
        .memEn_o(memEn_o), .memAddr_o(memAddr_o), .memWriteSel_o(memWriteSel_o),
        .memWdata_o(memWdata_o), .memRdata_i(memRdata_i), .dataStall_i(dataStall_i),
        .debugWbPc_o(debugWbPc_o), .debugWbRfWen_o(debugWbRfWen_o),
        .debugWbRfWnum_o(debugWbRfWnum_o), .debugWbRfWdata_o(debugWbRfWdata_o)
    );

    // both memories answer in the same cycle
    assign romOffset  = instAddr_o - bootVector;
    assign instr_i    = (romOffset[31:2] < progLen) ? rom[romOffset[6:2]] : '0;
    assign memRdata_i = {dmem[{memAddr_o[9:2], 2'd3}], dmem[{memAddr_o[9:2], 2'd2}],
                         dmem[{memAddr_o[9:2], 2'd1}], dmem[{memAddr_o[9:2], 2'd0}]};

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [7:0] fillByte(int a);
        logic [9:0] w;
        w = a[9:0];
        return w[7:0] ^ {4{w[9:8]}} ^ 8'hA5;  // every address bit matters
    endfunction

    function automatic wordT rInstr(functT fn, regIdxT rd, regIdxT rs, regIdxT rt,
                                    logic [4:0] sh);
        return {opSpecial, rs, rt, rd, sh, fn};
    endfunction

    function automatic wordT iInstr(opcodeT op, regIdxT rt, regIdxT rs, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wordT modelWord(wordT addr);
        return {modelMem[{addr[9:2], 2'd3}], modelMem[{addr[9:2], 2'd2}],
                modelMem[{addr[9:2], 2'd1}], modelMem[{addr[9:2], 2'd0}]};
    endfunction

    task automatic abortRun();
        $display("Regression failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic reportError(string msg);
        $display("ERROR %s: %s", testName, msg);
        abortRun();
    endtask

    task automatic checkWord(string what, wordT expVal, wordT actVal);
        if (actVal !== expVal) begin
            $display("FAIL %s %s expected %h actual %h", testName, what, expVal, actVal);
            abortRun();
        end
    endtask

    task automatic checkReg(string what, regIdxT expVal, regIdxT actVal);
        if (actVal !== expVal) begin
            $display("FAIL %s %s expected %0d actual %0d", testName, what, expVal, actVal);
            abortRun();
        end
    endtask

    task automatic checkSel(string what, logic [3:0] expVal, logic [3:0] actVal);
        if (actVal !== expVal) begin
            $display("FAIL %s %s expected %b actual %b", testName, what, expVal, actVal);
            abortRun();
        end
    endtask

    task automatic checkFlag(string what, logic expVal, logic actVal);
        if (actVal !== expVal) begin
            $display("FAIL %s %s expected %b actual %b", testName, what, expVal, actVal);
            abortRun();
        end
    endtask

    task automatic checkStore(storeEntryT e);
        checkWord("store address", e.addr, memAddr_o);
        checkSel("store enables", e.sel, memWriteSel_o);
        checkWord("store data", e.data, memWdata_o);
    endtask

    task automatic emit(wordT ins);
        rom[progLen] = ins;
        progLen++;
    endtask

    task automatic storeModel(wordT addr, logic [3:0] sel, wordT data);
        storeEntryT e;
        for (int lane = 0; lane < 4; lane++) begin
            if (sel[lane]) modelMem[{addr[9:2], 2'b00} + lane] = data[8*lane +: 8];
        end
        e.addr = addr;
        e.sel  = sel;
        e.data = data;
        expSt.push_back(e);
    endtask

    // instruction-level reference with one delay slot per branch
    task automatic runModel();
        wordT       ins, pc, npc, nextNpc, a, b, sImm, addr, res;
        opcodeT     op;
        functT      fn;
        regIdxT     rs, rt, rd, dest;
        logic [4:0] sh;
        logic [7:0] byteVal;
        logic       wr;
        wbEntryT    e;
        int         idx;
        for (int r = 0; r < 32; r++) modelRegs[r] = '0;
        pc  = bootVector;
        npc = bootVector + 32'd4;
        idx = 0;
        while (idx < progLen) begin
            ins = rom[idx];
            {op, rs, rt, rd, sh, fn} = ins;
            a       = modelRegs[rs];
            b       = modelRegs[rt];
            sImm    = {{16{ins[15]}}, ins[15:0]};
            addr    = a + sImm;
            byteVal = modelMem[addr[9:0]];
            nextNpc = npc + 32'd4;
            wr      = 1'b1;
            dest    = rt;
            res     = '0;
            case (op)
                opSpecial: begin
                    dest = rd;
                    case (fn)
                        fnAddu:  res = a + b;
                        fnSubu:  res = a - b;
                        fnAnd:   res = a & b;
                        fnOr:    res = a | b;
                        fnSlt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        fnSll:   res = b << sh;
                        default: wr = 1'b0;
                    endcase
                end
                opAddiu: res = addr;
                opOri:   res = a | {16'b0, ins[15:0]};
                opLui:   res = {ins[15:0], 16'b0};
                opLw:    res = modelWord(addr);
                opLb:    res = {{24{byteVal[7]}}, byteVal};
                opLbu:   res = {24'b0, byteVal};
                opSw: begin
                    wr = 1'b0;
                    storeModel(addr, 4'b1111, b);
                end
                opSb: begin
                    wr = 1'b0;
                    storeModel(addr, 4'b0001 << addr[1:0], {4{b[7:0]}});
                end
                opBeq, opBne: begin
                    wr = 1'b0;
                    if ((a == b) == (op == opBeq)) nextNpc = pc + 32'd4 + (sImm << 2);
                end
                default: wr = 1'b0;
            endcase
            if (wr && dest != '0) begin
                modelRegs[dest] = res;
                e.pc   = pc;
                e.num  = dest;
                e.data = res;
                expWb.push_back(e);
            end
            pc  = npc;
            npc = nextNpc;
            idx = (pc - bootVector) >> 2;
        end
    endtask

    task automatic startReset();
        @(posedge clk);
        #2;
        rstN_i  = 1'b0;
        progLen = 0;
    endtask

    task automatic finishReset();
        repeat (2) begin
            @(posedge clk);
            @(negedge clk);
            checkFlag("memory enable in reset", 1'b0, memEn_o);
            checkSel("writeback enables in reset", 4'b0000, debugWbRfWen_o);
        end
        @(posedge clk);
        #2;
        rstN_i = 1'b1;
    endtask

    // reset is low while the program and the reference run are set up
    task automatic runProgram(logic withStalls);
        lenSum += progLen;
        for (int a = 0; a < 1024; a++) begin
            dmem[a]     = fillByte(a);
            modelMem[a] = dmem[a];
        end
        runModel();
        finishReset();
        stallOn = withStalls;
        while (expWb.size() != 0 || expSt.size() != 0) @(posedge clk);
        stallOn = 1'b0;
        repeat (8) @(posedge clk);  // catch late extra writebacks
    endtask

    task automatic resetTest();
        testName = "reset";
        startReset();
        finishReset();
        @(negedge clk);
        checkFlag("memory enable after reset", 1'b0, memEn_o);
        checkSel("writeback enables after reset", 4'b0000, debugWbRfWen_o);
        @(negedge clk);
        checkWord("fetch address", bootVector, instAddr_o);
        checkFlag("fetch enable", 1'b1, instEn_o);
        checkFlag("memory enable", 1'b0, memEn_o);
        checkSel("writeback enables", 4'b0000, debugWbRfWen_o);
    endtask

    task automatic aluChainTest();
        logic [15:0] randImm;
        testName = "alu chain";
        startReset();
        rngState = xorshift32(rngState);
        randImm  = rngState[15:0];
        emit(iInstr(opAddiu, 1, 0, 16'h0005));
        emit(iInstr(opAddiu, 2, 1, 16'hFFFD));
        emit(rInstr(fnAddu, 3, 1, 2, 0));
        emit(rInstr(fnSubu, 4, 2, 3, 0));
        emit(rInstr(fnSlt, 5, 4, 1, 0));
        emit(rInstr(fnSll, 6, 0, 3, 5'd4));
        emit(iInstr(opOri, 7, 6, 16'h8001));
        emit(iInstr(opLui, 8, 0, 16'h8000));
        emit(rInstr(fnAnd, 9, 7, 3, 0));
        emit(rInstr(fnOr, 10, 8, 9, 0));
        emit(iInstr(opAddiu, 0, 1, 16'h0007));  // dropped write to $0
        emit(rInstr(fnAddu, 11, 0, 10, 0));
        emit(rInstr(fnSlt, 12, 8, 0, 0));
        emit(iInstr(opOri, 13, 0, randImm));
        emit(rInstr(fnAddu, 14, 13, 11, 0));
        emit(rInstr(fnSll, 15, 0, 14, 5'd31));
        runProgram(1'b0);
    endtask

    task automatic loadStoreTest(logic withStalls);
        testName = withStalls ? "load/store with data stalls" : "load/store";
        startReset();
        emit(iInstr(opAddiu, 1, 0, 16'h0100));
        emit(iInstr(opLui, 2, 0, 16'h8196));
        emit(iInstr(opOri, 2, 2, 16'hA5F7));
        emit(iInstr(opSw, 2, 1, 16'h0000));
        emit(iInstr(opLw, 3, 1, 16'h0000));
        emit(rInstr(fnAddu, 4, 3, 3, 0));  // load-use
        emit(iInstr(opLb, 5, 1, 16'h0001));
        emit(iInstr(opLbu, 6, 1, 16'h0003));
        emit(iInstr(opSb, 4, 1, 16'h0006));
        emit(iInstr(opLw, 7, 1, 16'h0004));
        emit(rInstr(fnOr, 8, 7, 5, 0));
        emit(iInstr(opOri, 9, 0, 16'h005A));
        emit(iInstr(opSb, 9, 1, 16'h0011));
        emit(iInstr(opLb, 10, 1, 16'h0011));
        emit(iInstr(opLbu, 11, 1, 16'h0012));
        emit(iInstr(opSw, 11, 1, 16'h0014));  // store data straight from a load
        emit(iInstr(opLw, 12, 1, 16'h0014));
        emit(iInstr(opLb, 13, 1, 16'h0021));
        emit(rInstr(fnSubu, 14, 13, 12, 0));
        runProgram(withStalls);
    endtask

    task automatic branchTest(logic withStalls);
        testName = withStalls ? "branches with data stalls" : "branches";
        startReset();
        emit(iInstr(opAddiu, 1, 0, 16'h0003));
        emit(iInstr(opAddiu, 2, 0, 16'h0003));
        emit(iInstr(opBeq, 2, 1, 16'h0002));  // taken
        emit(iInstr(opAddiu, 3, 0, 16'h0001));
        emit(iInstr(opAddiu, 4, 0, 16'h0001));
        emit(iInstr(opAddiu, 5, 2, 16'h0001));
        emit(iInstr(opBne, 1, 5, 16'h0002));  // taken
        emit(iInstr(opAddiu, 6, 0, 16'h0002));
        emit(iInstr(opAddiu, 7, 0, 16'h0002));
        emit(iInstr(opBeq, 1, 5, 16'h0002));  // not taken
        emit(iInstr(opAddiu, 8, 0, 16'h0003));
        emit(iInstr(opAddiu, 9, 0, 16'h0003));
        emit(iInstr(opAddiu, 10, 1, 16'h0001));
        emit(iInstr(opBne, 5, 10, 16'h0002));  // not taken
        emit(iInstr(opAddiu, 11, 0, 16'h0004));
        emit(iInstr(opAddiu, 12, 0, 16'h0004));
        emit(iInstr(opSw, 5, 0, 16'h0040));
        emit(iInstr(opLw, 13, 0, 16'h0040));
        emit(iInstr(opBeq, 5, 13, 16'h0002));  // operand from a load
        emit(iInstr(opAddiu, 14, 0, 16'h0005));
        emit(iInstr(opAddiu, 15, 0, 16'h0005));
        emit(iInstr(opAddiu, 16, 13, 16'h0001));
        runProgram(withStalls);
    endtask

    // stall level for the coming cycle
    always @(posedge clk) begin
        #2;
        if (stallOn) begin
            rngState    = xorshift32(rngState);
            dataStall_i = (rngState[1:0] == 2'b00);
        end else begin
            dataStall_i = 1'b0;
        end
    end

    // writeback and store monitor, mid-cycle when outputs are settled
    always @(negedge clk) begin
        if (rstN_i && debugWbRfWen_o != 4'b0000) begin
            if (dataStall_i) begin
                reportError("writeback reported while the data stall is high");
            end else if (debugWbRfWnum_o == '0) begin
                reportError("a write to register 0 was reported");
            end else if (expWb.size() == 0) begin
                reportError("writeback reported with none expected");
            end else begin
                wbExp = expWb.pop_front();
                checkSel("writeback enables", 4'b1111, debugWbRfWen_o);
                checkWord("writeback pc", wbExp.pc, debugWbPc_o);
                checkReg("writeback register", wbExp.num, debugWbRfWnum_o);
                checkWord("writeback data", wbExp.data, debugWbRfWdata_o);
            end
        end
        if (rstN_i && memEn_o && memWriteSel_o != 4'b0000 && !dataStall_i) begin
            if (expSt.size() == 0) begin
                reportError("store seen with none expected");
            end else begin
                stExp = expSt.pop_front();
                checkStore(stExp);
                for (int lane = 0; lane < 4; lane++) begin
                    if (memWriteSel_o[lane]) begin
                        dmem[{memAddr_o[9:2], 2'b00} + lane] = memWdata_o[8*lane +: 8];
                    end
                end
            end
        end
    end

    // limit grows with each program loaded
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > 4 * lenSum + 200) begin
            reportError($sformatf("timeout with %0d writebacks and %0d stores still expected",
                                  expWb.size(), expSt.size()));
        end
    end

    initial begin
        rstN_i      = 1'b0;
        dataStall_i = 1'b0;
        stallOn     = 1'b0;
        rngState    = 32'd74293;
        progLen     = 0;
        lenSum      = 0;
        cycleCount  = 0;
        testName    = "setup";
        for (int i = 0; i < 32; i++) rom[i] = '0;
        resetTest();
        aluChainTest();
        loadStoreTest(1'b0);
        branchTest(1'b0);
        loadStoreTest(1'b1);
        branchTest(1'b1);
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire
